//--- rtl/pulser_settings.svh
`ifndef PULSER_SETTINGS_SVH
`define PULSER_SETTINGS_SVH

// datapath widths
`define PULSER_NUM_CHAN    8
`define PULSER_CMD_W       16
`define PULSER_CHARGE_W    9
`define PULSER_PHASE_W     16
`define PULSER_FIRE_DLY_W  23
`define PULSER_RECV_DLY_W  32
`define PULSER_IRQ_W       32

// control-state codes, anything else behaves like idle
`define PULSER_CTRL_IDLE   2'd0
`define PULSER_CTRL_PIO    2'd1

// command word bits
`define PULSER_CMD_ISSUE_RCV  1
`define PULSER_CMD_FIRE       2
`define PULSER_CMD_SET_AMP    5
`define PULSER_CMD_SET_PHASE  6
`define PULSER_CMD_RESET_RCV  13
`define PULSER_CMD_RESET_IRQ  14
`define PULSER_CMD_NEW_CMD    15  // only there to force a change

// interrupt word bits
`define PULSER_IRQ_ALL_DONE      0
`define PULSER_IRQ_CMD_SEEN      1
`define PULSER_IRQ_FIRE_ACC      4
`define PULSER_IRQ_AMP_SET       5
`define PULSER_IRQ_PHASE_SET     6
`define PULSER_IRQ_RECV_ACC      8
`define PULSER_IRQ_FIRE_GO       9
`define PULSER_IRQ_FIRE_DONE     10
`define PULSER_IRQ_ADC_RAISED    12
`define PULSER_IRQ_RECV_ZERO     14
`define PULSER_IRQ_RECV_NONZERO  15
`define PULSER_IRQ_CHAN_LSB      16  // 16..23 mirror the channel done bits

`endif

//--- rtl/pulserPkg.sv
`include "pulser_settings.svh"

package pulserPkg;

	// flag view of the command word, msb first
	typedef struct packed {
		logic newCmd;     // 15
		logic resetIrq;   // 14
		logic resetRcv;   // 13
		logic spare12;
		logic spare11;
		logic spare10;
		logic spare9;
		logic spare8;
		logic spare7;
		logic setPhase;   // 6
		logic setAmp;     // 5
		logic spare4;
		logic spare3;
		logic fire;       // 2
		logic issueRcv;   // 1
		logic spare0;
	} cmdFlags_t;

	// raw view for change detection, flag view for the execute side
	typedef union packed {
		logic [`PULSER_CMD_W-1:0] raw;
		cmdFlags_t                flags;
	} pioCmd_u;

	typedef logic [`PULSER_NUM_CHAN-1:0][`PULSER_PHASE_W-1:0] phaseArr_t;

endpackage

//--- rtl/pulserIf.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

// decoded command strobe plus the idle-state clear
interface cmdIf;
	import pulserPkg::*;

	logic    cmdStb;
	pioCmd_u cmd;
	logic    clear;

	modport source (output cmdStb, cmd, clear);
	modport sink (input cmdStb, cmd, clear);
endinterface

// progress events from the execute stage
interface statusIf;
	logic                        fireAccepted;
	logic                        ampSet;
	logic                        phaseSet;
	logic                        fireGo;
	logic                        fireDone;
	logic                        fireBusy;
	logic [`PULSER_NUM_CHAN-1:0] chanDone;
	logic                        recvAccepted;
	logic                        recvDelayZero;
	logic                        adcRaised;
	logic                        recvPending;

	modport fireSource (output fireAccepted, ampSet, phaseSet, fireGo, fireDone, fireBusy,
		chanDone);
	modport recvSource (output recvAccepted, recvDelayZero, adcRaised, recvPending);
	modport monitor (input fireAccepted, ampSet, phaseSet, fireGo, fireDone, fireBusy,
		chanDone, recvAccepted, recvDelayZero, adcRaised, recvPending);
endinterface

//--- rtl/pioCmdDecode.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module pioCmdDecode (
	input  logic                     txCLK,
	input  logic                     rstN,
	input  logic [1:0]               ctrlState,
	input  logic [`PULSER_CMD_W-1:0] pioCmd,
	cmdIf.source                     cmd
);
	import pulserPkg::*;

	pioCmd_u curCmd;
	pioCmd_u prevCmd;     // last word seen, also the word presented with the strobe
	logic    stbQ;
	logic    pioMode;
	logic    cmdChanged;

	assign curCmd = pioCmd;
	assign pioMode = (ctrlState == `PULSER_CTRL_PIO);
	assign cmdChanged = (curCmd.raw != prevCmd.raw);

	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			prevCmd <= '0;
			stbQ <= 1'b0;
		end
		else if (!pioMode)
		begin
			// forget the old word so a held command fires again on return to PIO
			prevCmd <= '0;
			stbQ <= 1'b0;
		end
		else
		begin
			stbQ <= cmdChanged;
			if (cmdChanged)
			begin
				prevCmd <= curCmd;
			end
		end
	end

	// a strobe left over from the last PIO cycle is masked once the state drops
	assign cmd.cmdStb = stbQ & pioMode;
	assign cmd.cmd = prevCmd;
	assign cmd.clear = ~pioMode;

endmodule

//--- rtl/transducerChannel.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module transducerChannel (
	input  logic                        txCLK,
	input  logic                        rstN,
	input  logic                        clear,
	input  logic                        go,
	input  logic                        active,
	input  logic [`PULSER_CHARGE_W-1:0] chargeTime,
	input  logic [`PULSER_PHASE_W-1:0]  phaseDelay,
	output logic                        pulseOut,
	output logic                        done
);
	localparam int cntW = `PULSER_PHASE_W;

	localparam logic [1:0] stIdle   = 2'd0;
	localparam logic [1:0] stPhase  = 2'd1;
	localparam logic [1:0] stCharge = 2'd2;

	logic [1:0]      state;
	logic [cntW-1:0] cnt;
	logic [cntW-1:0] chargeLoad;

	assign chargeLoad = cntW'(chargeTime) - 1'b1;

	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= stIdle;
			cnt <= '0;
			done <= 1'b0;
		end
		else if (clear)
		begin
			state <= stIdle;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (go && !done)
					begin
						if (!active || chargeTime == '0)
							done <= 1'b1;   // nothing to drive
						else if (phaseDelay == '0)
						begin
							state <= stCharge;
							cnt <= chargeLoad;
						end
						else
						begin
							state <= stPhase;
							cnt <= phaseDelay - 1'b1;
						end
					end
				end
				stPhase:
				begin
					if (cnt == '0)
					begin
						state <= stCharge;
						cnt <= chargeLoad;
					end
					else
						cnt <= cnt - 1'b1;
				end
				stCharge:
				begin
					if (cnt == '0)
					begin
						state <= stIdle;
						done <= 1'b1;
					end
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= stIdle;
			endcase
		end
	end

	assign pulseOut = (state == stCharge);

endmodule

//--- rtl/fireSequencer.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module fireSequencer (
	input  logic                          txCLK,
	input  logic                          rstN,
	cmdIf.sink                            cmd,
	input  logic [`PULSER_NUM_CHAN-1:0]   transducerActive,
	input  logic [`PULSER_CHARGE_W-1:0]   chargeTime,
	input  pulserPkg::phaseArr_t          phaseDelays,
	input  logic [`PULSER_FIRE_DLY_W-1:0] fireDelay,
	statusIf.fireSource                   status,
	output logic [`PULSER_NUM_CHAN-1:0]   transducerOut
);
	import pulserPkg::*;

	logic                          fireArmed;   // fire delay running
	logic                          fireRun;     // channels running
	logic [`PULSER_FIRE_DLY_W-1:0] fireCnt;
	logic [`PULSER_CHARGE_W-1:0]   chargeReg;
	phaseArr_t                     phaseReg;
	logic [`PULSER_NUM_CHAN-1:0]   activeMask;
	logic [`PULSER_NUM_CHAN-1:0]   chanDone;
	logic                          busy;
	logic                          fireTake;
	logic                          ampTake;
	logic                          phaseTake;
	logic                          fireGo;
	logic                          fireDone;
	logic                          chanClear;

	assign busy = fireArmed | fireRun;
	assign fireTake = cmd.cmdStb & cmd.cmd.flags.fire & ~busy;
	assign ampTake = cmd.cmdStb & cmd.cmd.flags.setAmp & ~busy;
	assign phaseTake = cmd.cmdStb & cmd.cmd.flags.setPhase & ~busy;
	assign fireGo = fireArmed & (fireCnt == '0);
	assign fireDone = fireRun & (&chanDone);
	assign chanClear = cmd.clear | fireDone;

	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			fireArmed <= 1'b0;
			fireRun <= 1'b0;
			fireCnt <= '0;
		end
		else if (cmd.clear)
		begin
			fireArmed <= 1'b0;
			fireRun <= 1'b0;
			fireCnt <= '0;
		end
		else
		begin
			if (fireTake)
			begin
				fireArmed <= 1'b1;
				fireCnt <= fireDelay;
			end
			else if (fireGo)
			begin
				fireArmed <= 1'b0;
				fireRun <= 1'b1;
			end
			else if (fireArmed)
				fireCnt <= fireCnt - 1'b1;

			if (fireDone)
				fireRun <= 1'b0;
		end
	end

	// channel settings
	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			activeMask <= '0;
			chargeReg <= '0;
			phaseReg <= '0;
		end
		else if (cmd.clear)
		begin
			activeMask <= transducerActive;   // mask only follows the input in idle
			chargeReg <= '0;
			phaseReg <= '0;
		end
		else
		begin
			if (ampTake)
				chargeReg <= chargeTime;
			if (phaseTake)
				phaseReg <= phaseDelays;
		end
	end

	for (genvar ch = 0; ch < `PULSER_NUM_CHAN; ch++)
	begin : gChan
		transducerChannel i_chan (
			.txCLK      (txCLK),
			.rstN       (rstN),
			.clear      (chanClear),
			.go         (fireGo),
			.active     (activeMask[ch]),
			.chargeTime (chargeReg),
			.phaseDelay (phaseReg[ch]),
			.pulseOut   (transducerOut[ch]),
			.done       (chanDone[ch])
		);
	end

	assign status.fireAccepted = fireTake;
	assign status.ampSet = ampTake;
	assign status.phaseSet = phaseTake;
	assign status.fireGo = fireGo;
	assign status.fireDone = fireDone;
	assign status.fireBusy = busy;
	assign status.chanDone = chanDone;

endmodule

//--- rtl/recvTrigger.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module recvTrigger (
	input  logic                          txCLK,
	input  logic                          rstN,
	cmdIf.sink                            cmd,
	input  logic [`PULSER_RECV_DLY_W-1:0] recvTrigDelay,
	input  logic                          adcTrigAck,
	statusIf.recvSource                   status,
	output logic                          adcTrigger
);
	logic                          recvArmed;
	logic [`PULSER_RECV_DLY_W-1:0] recvCnt;
	logic                          pending;
	logic                          delayZero;
	logic                          abort;
	logic                          take;
	logic                          raise;

	assign pending = recvArmed | adcTrigger;
	assign delayZero = (recvTrigDelay == '0);
	assign abort = cmd.clear | (cmd.cmdStb & cmd.cmd.flags.resetRcv);
	assign take = cmd.cmdStb & cmd.cmd.flags.issueRcv & ~cmd.cmd.flags.resetRcv & ~pending;
	// trigger goes high at the end of this cycle
	assign raise = (take & delayZero) | (recvArmed & (recvCnt == '0));

	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			recvArmed <= 1'b0;
			recvCnt <= '0;
			adcTrigger <= 1'b0;
		end
		else if (abort)
		begin
			recvArmed <= 1'b0;
			recvCnt <= '0;
			adcTrigger <= 1'b0;
		end
		else
		begin
			if (take && !delayZero)
			begin
				recvArmed <= 1'b1;
				recvCnt <= recvTrigDelay - 1'b1;   // one cycle is spent loading
			end
			else if (recvArmed && recvCnt != '0)
				recvCnt <= recvCnt - 1'b1;

			if (raise)
			begin
				recvArmed <= 1'b0;
				adcTrigger <= 1'b1;
			end
			else if (adcTrigger && adcTrigAck)
				adcTrigger <= 1'b0;   // held until the receive side answers
		end
	end

	assign status.recvAccepted = take;
	assign status.recvDelayZero = delayZero;
	assign status.adcRaised = raise;
	assign status.recvPending = pending;

endmodule

//--- rtl/irqStatus.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module irqStatus (
	input  logic                     txCLK,
	input  logic                     rstN,
	cmdIf.sink                       cmd,
	statusIf.monitor                 status,
	output logic [`PULSER_IRQ_W-1:0] irq
);
	logic [`PULSER_IRQ_W-1:0] events;
	logic                     opSeen;   // fire or receive accepted since the last clear
	logic                     irqClear;
	logic                     idleNow;

	assign irqClear = cmd.clear | (cmd.cmdStb & cmd.cmd.flags.resetIrq);
	assign idleNow = opSeen & ~status.fireBusy & ~status.recvPending;

	always_comb
	begin
		events = '0;
		events[`PULSER_IRQ_ALL_DONE] = idleNow;
		events[`PULSER_IRQ_CMD_SEEN] = cmd.cmdStb;
		events[`PULSER_IRQ_FIRE_ACC] = status.fireAccepted;
		events[`PULSER_IRQ_AMP_SET] = status.ampSet;
		events[`PULSER_IRQ_PHASE_SET] = status.phaseSet;
		events[`PULSER_IRQ_RECV_ACC] = status.recvAccepted;
		events[`PULSER_IRQ_FIRE_GO] = status.fireGo;
		events[`PULSER_IRQ_FIRE_DONE] = status.fireDone;
		events[`PULSER_IRQ_ADC_RAISED] = status.adcRaised;
		events[`PULSER_IRQ_RECV_ZERO] = status.recvAccepted & status.recvDelayZero;
		events[`PULSER_IRQ_RECV_NONZERO] = status.recvAccepted & ~status.recvDelayZero;
	end

	always_ff @(posedge txCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			irq <= '0;
			opSeen <= 1'b0;
		end
		else if (irqClear)
		begin
			irq <= '0;
			opSeen <= 1'b0;
		end
		else
		begin
			if (status.fireAccepted || status.recvAccepted)
				opSeen <= 1'b1;
			irq <= irq | events;
			// not sticky, follows the channels
			irq[`PULSER_IRQ_CHAN_LSB +: `PULSER_NUM_CHAN] <= status.chanDone;
		end
	end

endmodule

//--- rtl/pulserTop.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module pulserTop (
	input  logic                          txCLK,
	input  logic                          rstN,
	input  logic [1:0]                    ctrlState,
	input  logic [`PULSER_CMD_W-1:0]      pioCmd,
	input  logic [`PULSER_NUM_CHAN-1:0]   transducerActive,
	input  logic [`PULSER_CHARGE_W-1:0]   chargeTime,
	input  pulserPkg::phaseArr_t          phaseDelays,
	input  logic [`PULSER_FIRE_DLY_W-1:0] fireDelay,
	input  logic [`PULSER_RECV_DLY_W-1:0] recvTrigDelay,
	input  logic                          adcTrigAck,
	output logic [`PULSER_NUM_CHAN-1:0]   transducerOut,
	output logic                          adcTrigger,
	output logic [`PULSER_IRQ_W-1:0]      irq
);
	cmdIf    cmdBus ();
	statusIf statusBus ();

	// decode
	pioCmdDecode i_decode (
		.txCLK     (txCLK),
		.rstN      (rstN),
		.ctrlState (ctrlState),
		.pioCmd    (pioCmd),
		.cmd       (cmdBus.source)
	);

	// execute, transmit side
	fireSequencer i_fire (
		.txCLK            (txCLK),
		.rstN             (rstN),
		.cmd              (cmdBus.sink),
		.transducerActive (transducerActive),
		.chargeTime       (chargeTime),
		.phaseDelays      (phaseDelays),
		.fireDelay        (fireDelay),
		.status           (statusBus.fireSource),
		.transducerOut    (transducerOut)
	);

	// execute, receive side
	recvTrigger i_recv (
		.txCLK         (txCLK),
		.rstN          (rstN),
		.cmd           (cmdBus.sink),
		.recvTrigDelay (recvTrigDelay),
		.adcTrigAck    (adcTrigAck),
		.status        (statusBus.recvSource),
		.adcTrigger    (adcTrigger)
	);

	// result
	irqStatus i_irq (
		.txCLK  (txCLK),
		.rstN   (rstN),
		.cmd    (cmdBus.sink),
		.status (statusBus.monitor),
		.irq    (irq)
	);

endmodule

//--- verif/pulserTb.sv
`timescale 1ns/1ps
`include "pulser_settings.svh"

module pulserTb;
	import pulserPkg::*;

	localparam logic [15:0] cmdIssue = 16'h1 << `PULSER_CMD_ISSUE_RCV;
	localparam logic [15:0] cmdFire = 16'h1 << `PULSER_CMD_FIRE;
	localparam logic [15:0] cmdSet = (16'h1 << `PULSER_CMD_SET_AMP) |
		(16'h1 << `PULSER_CMD_SET_PHASE);
	localparam logic [15:0] cmdResetRcv = 16'h1 << `PULSER_CMD_RESET_RCV;
	localparam logic [15:0] cmdResetIrq = 16'h1 << `PULSER_CMD_RESET_IRQ;
	localparam logic [31:0] recvMask = (32'h1 << `PULSER_IRQ_RECV_ACC) |
		(32'h1 << `PULSER_IRQ_ADC_RAISED) | (32'h1 << `PULSER_IRQ_RECV_NONZERO);

	logic                          txCLK;
	logic                          rstN;
	logic [1:0]                    ctrlState;
	logic [`PULSER_CMD_W-1:0]      pioCmd;
	logic [`PULSER_NUM_CHAN-1:0]   transducerActive;
	logic [`PULSER_CHARGE_W-1:0]   chargeTime;
	phaseArr_t                     phaseDelays;
	logic [`PULSER_FIRE_DLY_W-1:0] fireDelay;
	logic [`PULSER_RECV_DLY_W-1:0] recvTrigDelay;
	logic                          adcTrigAck;
	logic [`PULSER_NUM_CHAN-1:0]   transducerOut;
	logic                          adcTrigger;
	logic [`PULSER_IRQ_W-1:0]      irq;

	logic [31:0] lfsrState;
	logic [7:0]  maskR;
	int          chargeR;
	int          charge2;   // rejected while busy
	phaseArr_t   phaseR;
	phaseArr_t   phase2;
	int          maxPhase;
	int          fireDlyR;
	int          recvDlyR;
	int          budgetCycles = 0;
	logic [31:0] irqExp;
	int          errCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          testErrBase = 0;

	// pulse monitor state
	int          cyc = 0;
	int          rises [`PULSER_NUM_CHAN];
	int          widths [`PULSER_NUM_CHAN];
	int          riseCyc [`PULSER_NUM_CHAN];
	int          totalRises = 0;
	logic [7:0]  prevOut = '0;

	pulserTop i_dut (
		.txCLK            (txCLK),
		.rstN             (rstN),
		.ctrlState        (ctrlState),
		.pioCmd           (pioCmd),
		.transducerActive (transducerActive),
		.chargeTime       (chargeTime),
		.phaseDelays      (phaseDelays),
		.fireDelay        (fireDelay),
		.recvTrigDelay    (recvTrigDelay),
		.adcTrigAck       (adcTrigAck),
		.transducerOut    (transducerOut),
		.adcTrigger       (adcTrigger),
		.irq              (irq)
	);

	initial
	begin
		txCLK = 1'b0;
		forever #20 txCLK = ~txCLK;
	end

	always @(posedge txCLK)
		cyc = cyc + 1;

	// outputs move on the rising edge, so look in mid cycle
	always @(negedge txCLK)
	begin
		for (int ch = 0; ch < `PULSER_NUM_CHAN; ch++)
		begin
			if (transducerOut[ch])
			begin
				if (!prevOut[ch])
				begin
					rises[ch]++;
					riseCyc[ch] = cyc;
					totalRises++;
				end
				widths[ch]++;
			end
		end
		prevOut = transducerOut;
	end

	// galois form, taps 32 22 2 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int randBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsrState[0]);
			lfsrState = nextLfsr(lfsrState);
		end
		return v;
	endfunction

	// settled irq once a command word has been taken and its operation has run out
	function automatic logic [31:0] expectIrq(input logic [31:0] sofar, input logic [15:0] word,
		input logic fireBusy, input logic recvPend, input logic recvZero);
		logic [31:0] r;
		logic        fireOk;
		logic        recvOk;
		if (word[`PULSER_CMD_RESET_IRQ])
			return '0;   // the clear wins over everything else in that cycle
		r = sofar;
		r[`PULSER_IRQ_CMD_SEEN] = 1'b1;
		fireOk = word[`PULSER_CMD_FIRE] & ~fireBusy;
		recvOk = word[`PULSER_CMD_ISSUE_RCV] & ~word[`PULSER_CMD_RESET_RCV] & ~recvPend;
		if (fireOk)
			r |= (32'h1 << `PULSER_IRQ_FIRE_ACC) | (32'h1 << `PULSER_IRQ_FIRE_GO) |
				(32'h1 << `PULSER_IRQ_FIRE_DONE);
		if (word[`PULSER_CMD_SET_AMP] && !fireBusy)
			r[`PULSER_IRQ_AMP_SET] = 1'b1;
		if (word[`PULSER_CMD_SET_PHASE] && !fireBusy)
			r[`PULSER_IRQ_PHASE_SET] = 1'b1;
		if (recvOk)
		begin
			r[`PULSER_IRQ_RECV_ACC] = 1'b1;
			r[`PULSER_IRQ_ADC_RAISED] = 1'b1;
			r[recvZero ? `PULSER_IRQ_RECV_ZERO : `PULSER_IRQ_RECV_NONZERO] = 1'b1;
		end
		if (fireOk || recvOk)
			r[`PULSER_IRQ_ALL_DONE] = 1'b1;
		return r;
	endfunction

	// high time and rise offset against the earliest active channel
	function automatic void expectPulse(input int ch, input logic [7:0] mask, input int charge,
		input phaseArr_t phases, output int width, output int offset);
		int minPhase;
		minPhase = 1 << 16;
		for (int i = 0; i < `PULSER_NUM_CHAN; i++)
			if (mask[i] && phases[i] < minPhase)
				minPhase = phases[i];
		width = mask[ch] ? charge : 0;
		offset = mask[ch] ? phases[ch] - minPhase : 0;
	endfunction

	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge txCLK);
			#5;
		end
	endtask

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			$display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
			errCount++;
		end
	endtask

	task automatic waitIrqBit(input int bitPos, input int limit);
		int n;
		n = 0;
		while (irq[bitPos] !== 1'b1 && n < limit)
		begin
			step(1);
			n++;
		end
		assert (irq[bitPos] === 1'b1)
		else
		begin
			$display("Error at %0t ns: irq bit %0d did not set within %0d cycles",
				$time, bitPos, limit);
			errCount++;
		end
	endtask

	task automatic waitTrigger(input logic level, input int limit);
		int n;
		n = 0;
		while (adcTrigger !== level && n < limit)
		begin
			step(1);
			n++;
		end
		assert (adcTrigger === level)
		else
		begin
			$display("Error at %0t ns: adcTrigger did not go to %b within %0d cycles",
				$time, level, limit);
			errCount++;
		end
	endtask

	task automatic clearPulses();
		for (int ch = 0; ch < `PULSER_NUM_CHAN; ch++)
		begin
			rises[ch] = 0;
			widths[ch] = 0;
		end
		totalRises = 0;
	endtask

	task automatic checkPulses();
		int expWidth;
		int expOffset;
		int firstRise;
		firstRise = -1;
		for (int ch = 0; ch < `PULSER_NUM_CHAN; ch++)
			if (rises[ch] != 0 && (firstRise < 0 || riseCyc[ch] < firstRise))
				firstRise = riseCyc[ch];
		for (int ch = 0; ch < `PULSER_NUM_CHAN; ch++)
		begin
			expectPulse(ch, maskR, chargeR, phaseR, expWidth, expOffset);
			compare($sformatf("transducerOut[%0d] pulses", ch), rises[ch], (expWidth != 0));
			compare($sformatf("transducerOut[%0d] width", ch), widths[ch], expWidth);
			if (expWidth != 0)
				compare($sformatf("transducerOut[%0d] offset", ch), riseCyc[ch] - firstRise,
					expOffset);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		$display("test %0d %s: %s", testCount, name, (errCount == testErrBase) ? "ok" : "errors");
		testErrBase = errCount;
	endtask

	initial
	begin
		rstN = 1'b0;
		ctrlState = `PULSER_CTRL_IDLE;
		pioCmd = '0;
		adcTrigAck = 1'b0;
		irqExp = '0;
		lfsrState = 32'hf799_4dfa;
		maskR = (8'(randBits(8)) | 8'h01) & 8'h7f;   // channel 7 stays inactive
		chargeR = 1 + randBits(5) % 31;
		charge2 = 1 + randBits(5) % 31;
		if (charge2 == chargeR)
			charge2 = chargeR % 31 + 1;
		maxPhase = 0;
		for (int ch = 0; ch < `PULSER_NUM_CHAN; ch++)
		begin
			phaseR[ch] = 16'(randBits(6));
			phase2[ch] = 16'(randBits(6));
			if (phaseR[ch] > maxPhase)
				maxPhase = phaseR[ch];
		end
		fireDlyR = 4 + randBits(5);
		recvDlyR = 1 + randBits(5);
		transducerActive = maskR;
		chargeTime = 9'(chargeR);
		phaseDelays = phaseR;
		fireDelay = 23'(fireDlyR);
		recvTrigDelay = 32'(recvDlyR);
		// three fires and the quiet window, plus the receive delay
		budgetCycles = 4 * (fireDlyR + maxPhase + chargeR) + recvDlyR + 200;
		repeat (3) @(posedge txCLK);
		#5 rstN = 1'b1;

		step(2);
		compare("transducerOut", transducerOut, 0);
		compare("adcTrigger", adcTrigger, 0);
		compare("irq", irq, 0);
		endTest("reset and idle outputs");

		ctrlState = `PULSER_CTRL_PIO;   // mask was latched while idle
		step(1);
		clearPulses();
		pioCmd = cmdSet;
		irqExp = expectIrq(irqExp, cmdSet, 1'b0, 1'b0, 1'b0);
		step(2);
		pioCmd = cmdFire;
		irqExp = expectIrq(irqExp, cmdFire, 1'b0, 1'b0, 1'b0);
		waitIrqBit(`PULSER_IRQ_FIRE_GO, fireDlyR + 8);
		step(1);   // inactive channels report done right after go
		compare("irq channel done", irq[`PULSER_IRQ_CHAN_LSB +: `PULSER_NUM_CHAN],
			{24'h0, ~maskR});
		waitIrqBit(`PULSER_IRQ_ALL_DONE, fireDlyR + maxPhase + chargeR + 20);
		checkPulses();
		compare("irq", irq, irqExp);
		endTest("fire with phase and charge");

		pioCmd = cmdResetIrq;
		irqExp = expectIrq(irqExp, cmdResetIrq, 1'b0, 1'b0, 1'b0);
		step(3);
		compare("irq", irq, irqExp);
		pioCmd = cmdIssue;
		irqExp = expectIrq(irqExp, cmdIssue, 1'b0, 1'b0, recvDlyR == 0);
		waitTrigger(1'b1, recvDlyR + 8);
		compare("irq receive bits", irq & recvMask, irqExp & recvMask);
		compare("irq[0]", irq[`PULSER_IRQ_ALL_DONE], 0);   // trigger still pending
		repeat (4)
		begin
			step(1);
			compare("adcTrigger", adcTrigger, 1);
		end
		adcTrigAck = 1'b1;
		waitTrigger(1'b0, 4);
		adcTrigAck = 1'b0;
		waitIrqBit(`PULSER_IRQ_ALL_DONE, 8);
		compare("irq", irq, irqExp);
		endTest("delayed receive trigger");

		recvTrigDelay = '0;
		pioCmd = cmdResetIrq;
		irqExp = expectIrq(irqExp, cmdResetIrq, 1'b0, 1'b0, 1'b0);
		step(3);
		pioCmd = cmdIssue;
		irqExp = expectIrq(irqExp, cmdIssue, 1'b0, 1'b0, 1'b1);
		waitTrigger(1'b1, 8);
		compare("irq[14]", irq[`PULSER_IRQ_RECV_ZERO], 1);
		compare("irq[15]", irq[`PULSER_IRQ_RECV_NONZERO], 0);
		pioCmd = cmdResetRcv;   // abort without an acknowledge
		irqExp = expectIrq(irqExp, cmdResetRcv, 1'b0, 1'b1, 1'b1);
		waitTrigger(1'b0, 8);
		waitIrqBit(`PULSER_IRQ_ALL_DONE, 8);
		compare("irq", irq, irqExp);
		endTest("zero-delay trigger and abort");

		pioCmd = cmdResetIrq;
		irqExp = expectIrq(irqExp, cmdResetIrq, 1'b0, 1'b0, 1'b0);
		step(3);
		clearPulses();
		pioCmd = cmdFire;
		irqExp = expectIrq(irqExp, cmdFire, 1'b0, 1'b0, 1'b0);
		waitIrqBit(`PULSER_IRQ_FIRE_ACC, 8);
		// new settings arrive while the fire delay runs
		chargeTime = 9'(charge2);
		phaseDelays = phase2;
		pioCmd = cmdSet;
		irqExp = expectIrq(irqExp, cmdSet, 1'b1, 1'b0, 1'b0);
		waitIrqBit(`PULSER_IRQ_ALL_DONE, fireDlyR + maxPhase + chargeR + 20);
		checkPulses();   // old widths and offsets
		compare("irq", irq, irqExp);
		pioCmd = cmdResetIrq;
		irqExp = expectIrq(irqExp, cmdResetIrq, 1'b0, 1'b0, 1'b0);
		step(3);
		compare("irq", irq, irqExp);
		pioCmd = cmdFire;
		irqExp = expectIrq(irqExp, cmdFire, 1'b0, 1'b0, 1'b0);
		waitIrqBit(`PULSER_IRQ_ALL_DONE, fireDlyR + maxPhase + chargeR + 20);
		clearPulses();
		pioCmd = cmdFire;   // same word again, NEW_CMD left alone
		step(fireDlyR + maxPhase + chargeR + 10);
		compare("transducerOut rises", totalRises, 0);
		compare("irq", irq, irqExp);
		endTest("busy updates and repeated command");

		ctrlState = `PULSER_CTRL_IDLE;   // irq still holds the last fire here
		step(2);
		compare("transducerOut", transducerOut, 0);
		compare("adcTrigger", adcTrigger, 0);
		compare("irq", irq, 0);
		endTest("idle clears outputs");

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
		if (errCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial
	begin
		wait (budgetCycles > 0);
		#(budgetCycles * 40);
		$display("watchdog: run did not finish within %0d cycles", budgetCycles);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- pulser.f
+incdir+rtl
rtl/pulserPkg.sv
rtl/pulserIf.sv
rtl/pioCmdDecode.sv
rtl/transducerChannel.sv
rtl/fireSequencer.sv
rtl/recvTrigger.sv
rtl/irqStatus.sv
rtl/pulserTop.sv
verif/pulserTb.sv

//--- Bender.yml
package:
  name: pulser

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pulserPkg.sv
      - rtl/pulserIf.sv
      - rtl/pioCmdDecode.sv
      - rtl/transducerChannel.sv
      - rtl/fireSequencer.sv
      - rtl/recvTrigger.sv
      - rtl/irqStatus.sv
      - rtl/pulserTop.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/pulserTb.sv
